// ==== logic/core_pkg.sv ====
package core_pkg;

    // datapath and register file sizes
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 1 << reg_addr_w;

    // alu operation codes
    localparam int alu_op_w = 3;

    typedef enum logic [alu_op_w-1:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        // shifts use the low 5 bits of operand b
        op_sll = 3'd5,
        op_srl = 3'd6,
        // signed compare, result is 1 or 0
        op_slt = 3'd7
    } alu_op_e;

    // edges from the issue sample up to a visible writeback,
    // counting issue, operand read, exe1 and wb registers
    localparam int pipe_latency = 4;

endpackage

// ==== logic/dual_issue_core.sv ====
`timescale 1ns/1ns

module dual_issue_core
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  issue_valid_0, issue_valid_1,
    input  alu_op_e               op_0, op_1,
    input  logic [reg_addr_w-1:0] rd_0, rd_1,
    input  logic [reg_addr_w-1:0] rj_0, rj_1,
    input  logic [reg_addr_w-1:0] rk_0, rk_1,
    input  logic [xlen-1:0]       imm_0, imm_1,
    input  logic                  use_imm_0, use_imm_1,
    output logic                  wb_en_0, wb_en_1,
    output logic [reg_addr_w-1:0] wb_addr_0, wb_addr_1,
    output logic [xlen-1:0]       wb_data_0, wb_data_1
);

    // operand read stage outputs
    logic                  ex_valid_0, ex_valid_1;
    alu_op_e               ex_op_0, ex_op_1;
    logic [reg_addr_w-1:0] ex_rd_0, ex_rd_1;
    logic [reg_addr_w-1:0] ex_rj_0, ex_rj_1;
    logic [reg_addr_w-1:0] ex_rk_0, ex_rk_1;
    logic [xlen-1:0]       ex_imm_0, ex_imm_1;
    logic                  ex_use_imm_0, ex_use_imm_1;
    logic [xlen-1:0]       ex_rrj_0, ex_rrj_1;
    logic [xlen-1:0]       ex_rrk_0, ex_rrk_1;

    // in-flight results and forwarded operands
    logic                  e1_valid_0, e1_valid_1;
    logic [reg_addr_w-1:0] e1_rd_0, e1_rd_1;
    logic [xlen-1:0]       e1_result_0, e1_result_1;
    logic [xlen-1:0]       fwd_rj_0, fwd_rk_0;
    logic [xlen-1:0]       fwd_rj_1, fwd_rk_1;

    // writeback ports close the loop into the register file
    operand_stage u_operand_stage (
        .wr_en_0   (wb_en_0),
        .wr_en_1   (wb_en_1),
        .wr_addr_0 (wb_addr_0),
        .wr_addr_1 (wb_addr_1),
        .wr_data_0 (wb_data_0),
        .wr_data_1 (wb_data_1),
        .*
    );

    forward_unit u_forward_unit (
        .wb_valid_0  (wb_en_0),
        .wb_valid_1  (wb_en_1),
        .wb_rd_0     (wb_addr_0),
        .wb_rd_1     (wb_addr_1),
        .wb_result_0 (wb_data_0),
        .wb_result_1 (wb_data_1),
        .*
    );

    exe_lane lane0 (
        .clk        (clk),
        .rstn       (rstn),
        .ex_valid   (ex_valid_0),
        .ex_op      (ex_op_0),
        .ex_rd      (ex_rd_0),
        .ex_imm     (ex_imm_0),
        .ex_use_imm (ex_use_imm_0),
        .fwd_rj     (fwd_rj_0),
        .fwd_rk     (fwd_rk_0),
        .e1_valid   (e1_valid_0),
        .e1_rd      (e1_rd_0),
        .e1_result  (e1_result_0),
        .wb_en      (wb_en_0),
        .wb_addr    (wb_addr_0),
        .wb_data    (wb_data_0)
    );

    exe_lane lane1 (
        .clk        (clk),
        .rstn       (rstn),
        .ex_valid   (ex_valid_1),
        .ex_op      (ex_op_1),
        .ex_rd      (ex_rd_1),
        .ex_imm     (ex_imm_1),
        .ex_use_imm (ex_use_imm_1),
        .fwd_rj     (fwd_rj_1),
        .fwd_rk     (fwd_rk_1),
        .e1_valid   (e1_valid_1),
        .e1_rd      (e1_rd_1),
        .e1_result  (e1_result_1),
        .wb_en      (wb_en_1),
        .wb_addr    (wb_addr_1),
        .wb_data    (wb_data_1)
    );

endmodule

// ==== logic/exe_lane.sv ====
`timescale 1ns/1ns

module exe_lane
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  ex_valid,
    input  alu_op_e               ex_op,
    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic [xlen-1:0]       ex_imm,
    input  logic                  ex_use_imm,
    input  logic [xlen-1:0]       fwd_rj,
    input  logic [xlen-1:0]       fwd_rk,
    output logic                  e1_valid,
    output logic [reg_addr_w-1:0] e1_rd,
    output logic [xlen-1:0]       e1_result,
    output logic                  wb_en,
    output logic [reg_addr_w-1:0] wb_addr,
    output logic [xlen-1:0]       wb_data
);

    logic [xlen-1:0] opnd_b;
    logic [xlen-1:0] alu_result;
    logic [4:0]      shamt;

    assign opnd_b = ex_use_imm ? ex_imm : fwd_rk;
    assign shamt  = opnd_b[4:0];

    // exe0 alu
    always_comb begin
        alu_result = '0;
        case (ex_op)
            op_add: alu_result = fwd_rj + opnd_b;
            op_sub: alu_result = fwd_rj - opnd_b;
            op_and: alu_result = fwd_rj & opnd_b;
            op_or:  alu_result = fwd_rj | opnd_b;
            op_xor: alu_result = fwd_rj ^ opnd_b;
            op_sll: alu_result = fwd_rj << shamt;
            op_srl: alu_result = fwd_rj >> shamt;
            op_slt: alu_result = {{(xlen-1){1'b0}}, $signed(fwd_rj) < $signed(opnd_b)};
            default: alu_result = '0;
        endcase
    end

    // exe0 to exe1
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            e1_valid  <= 1'b0;
            e1_rd     <= '0;
            e1_result <= '0;
        end else begin
            e1_valid  <= ex_valid;
            e1_rd     <= ex_rd;
            e1_result <= alu_result;
        end
    end

    // register zero never reaches the register file
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb_en   <= 1'b0;
            wb_addr <= '0;
            wb_data <= '0;
        end else begin
            wb_en   <= e1_valid && e1_rd != '0;
            wb_addr <= e1_rd;
            wb_data <= e1_result;
        end
    end

endmodule

// ==== logic/forward_unit.sv ====
`timescale 1ns/1ns

module forward_unit
    import core_pkg::*;
(
    input  logic [reg_addr_w-1:0] ex_rj_0, ex_rk_0,
    input  logic [reg_addr_w-1:0] ex_rj_1, ex_rk_1,
    input  logic [xlen-1:0]       ex_rrj_0, ex_rrk_0,
    input  logic [xlen-1:0]       ex_rrj_1, ex_rrk_1,
    input  logic                  e1_valid_0, e1_valid_1,
    input  logic [reg_addr_w-1:0] e1_rd_0, e1_rd_1,
    input  logic [xlen-1:0]       e1_result_0, e1_result_1,
    input  logic                  wb_valid_0, wb_valid_1,
    input  logic [reg_addr_w-1:0] wb_rd_0, wb_rd_1,
    input  logic [xlen-1:0]       wb_result_0, wb_result_1,
    output logic [xlen-1:0]       fwd_rj_0, fwd_rk_0,
    output logic [xlen-1:0]       fwd_rj_1, fwd_rk_1
);

    // newest value wins: exe1 before wb, lane 1 before lane 0
    function automatic logic [xlen-1:0] pick(input logic [reg_addr_w-1:0] src,
                                             input logic [xlen-1:0]       rf_val);
        if (src == '0) begin
            return rf_val;
        end else if (e1_valid_1 && e1_rd_1 == src) begin
            return e1_result_1;
        end else if (e1_valid_0 && e1_rd_0 == src) begin
            return e1_result_0;
        end else if (wb_valid_1 && wb_rd_1 == src) begin
            return wb_result_1;
        end else if (wb_valid_0 && wb_rd_0 == src) begin
            return wb_result_0;
        end
        // older values already come out of the register file
        return rf_val;
    endfunction

    always_comb begin
        fwd_rj_0 = pick(ex_rj_0, ex_rrj_0);
        fwd_rk_0 = pick(ex_rk_0, ex_rrk_0);
        fwd_rj_1 = pick(ex_rj_1, ex_rrj_1);
        fwd_rk_1 = pick(ex_rk_1, ex_rrk_1);
    end

endmodule

// ==== logic/operand_stage.sv ====
`timescale 1ns/1ns

module operand_stage
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  issue_valid_0, issue_valid_1,
    input  alu_op_e               op_0, op_1,
    input  logic [reg_addr_w-1:0] rd_0, rd_1,
    input  logic [reg_addr_w-1:0] rj_0, rj_1,
    input  logic [reg_addr_w-1:0] rk_0, rk_1,
    input  logic [xlen-1:0]       imm_0, imm_1,
    input  logic                  use_imm_0, use_imm_1,
    input  logic                  wr_en_0, wr_en_1,
    input  logic [reg_addr_w-1:0] wr_addr_0, wr_addr_1,
    input  logic [xlen-1:0]       wr_data_0, wr_data_1,
    output logic                  ex_valid_0, ex_valid_1,
    output alu_op_e               ex_op_0, ex_op_1,
    output logic [reg_addr_w-1:0] ex_rd_0, ex_rd_1,
    output logic [reg_addr_w-1:0] ex_rj_0, ex_rj_1,
    output logic [reg_addr_w-1:0] ex_rk_0, ex_rk_1,
    output logic [xlen-1:0]       ex_imm_0, ex_imm_1,
    output logic                  ex_use_imm_0, ex_use_imm_1,
    output logic [xlen-1:0]       ex_rrj_0, ex_rrj_1,
    output logic [xlen-1:0]       ex_rrk_0, ex_rrk_1
);

    logic                  iss_valid_0, iss_valid_1;
    alu_op_e               iss_op_0, iss_op_1;
    logic [reg_addr_w-1:0] iss_rd_0, iss_rd_1;
    logic [reg_addr_w-1:0] iss_rj_0, iss_rj_1;
    logic [reg_addr_w-1:0] iss_rk_0, iss_rk_1;
    logic [xlen-1:0]       iss_imm_0, iss_imm_1;
    logic                  iss_use_imm_0, iss_use_imm_1;
    logic [xlen-1:0]       rf_rj_0, rf_rk_0, rf_rj_1, rf_rk_1;

    // issue register
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            iss_valid_0 <= 1'b0;
            iss_valid_1 <= 1'b0;
            iss_op_0    <= op_add;
            iss_op_1    <= op_add;
            {iss_rd_0, iss_rj_0, iss_rk_0, iss_imm_0, iss_use_imm_0} <= '0;
            {iss_rd_1, iss_rj_1, iss_rk_1, iss_imm_1, iss_use_imm_1} <= '0;
        end else begin
            iss_valid_0 <= issue_valid_0;
            iss_valid_1 <= issue_valid_1;
            iss_op_0    <= op_0;
            iss_op_1    <= op_1;
            {iss_rd_0, iss_rj_0, iss_rk_0, iss_imm_0, iss_use_imm_0}
                <= {rd_0, rj_0, rk_0, imm_0, use_imm_0};
            {iss_rd_1, iss_rj_1, iss_rk_1, iss_imm_1, iss_use_imm_1}
                <= {rd_1, rj_1, rk_1, imm_1, use_imm_1};
        end
    end

    register_file u_register_file (
        .clk       (clk),
        .rstn      (rstn),
        .wr_en_0   (wr_en_0),
        .wr_en_1   (wr_en_1),
        .wr_addr_0 (wr_addr_0),
        .wr_addr_1 (wr_addr_1),
        .wr_data_0 (wr_data_0),
        .wr_data_1 (wr_data_1),
        .raddr_0   (iss_rj_0),
        .raddr_1   (iss_rk_0),
        .raddr_2   (iss_rj_1),
        .raddr_3   (iss_rk_1),
        .rdata_0   (rf_rj_0),
        .rdata_1   (rf_rk_0),
        .rdata_2   (rf_rj_1),
        .rdata_3   (rf_rk_1)
    );

    // operand read register, feeds exe0
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ex_valid_0 <= 1'b0;
            ex_valid_1 <= 1'b0;
            ex_op_0    <= op_add;
            ex_op_1    <= op_add;
            {ex_rd_0, ex_rj_0, ex_rk_0, ex_imm_0, ex_use_imm_0, ex_rrj_0, ex_rrk_0} <= '0;
            {ex_rd_1, ex_rj_1, ex_rk_1, ex_imm_1, ex_use_imm_1, ex_rrj_1, ex_rrk_1} <= '0;
        end else begin
            ex_valid_0 <= iss_valid_0;
            ex_valid_1 <= iss_valid_1;
            ex_op_0    <= iss_op_0;
            ex_op_1    <= iss_op_1;
            {ex_rd_0, ex_rj_0, ex_rk_0, ex_imm_0, ex_use_imm_0, ex_rrj_0, ex_rrk_0}
                <= {iss_rd_0, iss_rj_0, iss_rk_0, iss_imm_0, iss_use_imm_0, rf_rj_0, rf_rk_0};
            {ex_rd_1, ex_rj_1, ex_rk_1, ex_imm_1, ex_use_imm_1, ex_rrj_1, ex_rrk_1}
                <= {iss_rd_1, iss_rj_1, iss_rk_1, iss_imm_1, iss_use_imm_1, rf_rj_1, rf_rk_1};
        end
    end

    // no forwarding path exists between the two lanes of one pair
    a_no_pair_dependency : assert property (@(posedge clk) disable iff (!rstn)
        (issue_valid_0 && issue_valid_1 && rd_0 != '0)
            |-> (rj_1 != rd_0 && (use_imm_1 || rk_1 != rd_0)))
        else $error("lane 1 reads the register lane 0 writes in the same pair");

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/1ns

module register_file
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  wr_en_0,
    input  logic                  wr_en_1,
    input  logic [reg_addr_w-1:0] wr_addr_0,
    input  logic [reg_addr_w-1:0] wr_addr_1,
    input  logic [xlen-1:0]       wr_data_0,
    input  logic [xlen-1:0]       wr_data_1,
    input  logic [reg_addr_w-1:0] raddr_0,
    input  logic [reg_addr_w-1:0] raddr_1,
    input  logic [reg_addr_w-1:0] raddr_2,
    input  logic [reg_addr_w-1:0] raddr_3,
    output logic [xlen-1:0]       rdata_0,
    output logic [xlen-1:0]       rdata_1,
    output logic [xlen-1:0]       rdata_2,
    output logic [xlen-1:0]       rdata_3
);

    logic [xlen-1:0] regs [num_regs];

    // lane 1 is written last so it wins a same-address collision
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_en_0 && wr_addr_0 != '0) begin
                regs[wr_addr_0] <= wr_data_0;
            end
            if (wr_en_1 && wr_addr_1 != '0) begin
                regs[wr_addr_1] <= wr_data_1;
            end
        end
    end

    // write-through read, same lane priority as the storage
    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wr_en_1 && wr_addr_1 == addr) begin
            return wr_data_1;
        end else if (wr_en_0 && wr_addr_0 == addr) begin
            return wr_data_0;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata_0 = read_port(raddr_0);
        rdata_1 = read_port(raddr_1);
        rdata_2 = read_port(raddr_2);
        rdata_3 = read_port(raddr_3);
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dual issue core testbench with verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns -f verilog.f \
    --top-module tb_dual_issue_core -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_dual_issue_core > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0

// ==== test/core_cases.txt ====
# per lane: valid op rd rj rk imm(hex) use_imm expected_wb_data(hex), lane 0 first
# op: 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 slt
1 0 1 20 0 00000015 1 00000015   1 1 2 21 0 00000005 1 fffffffb
1 2 3 22 0 000000ff 1 00000000   1 3 4 23 0 0000a5a5 1 0000a5a5
1 4 5 24 0 00000f0f 1 00000f0f   1 5 6 25 0 00000003 1 00000000
1 6 7 26 0 00000002 1 00000000   1 7 8 27 0 00000007 1 00000001
1 0 9 1 2 00000000 0 00000010   1 5 10 4 0 00000004 1 000a5a50
1 1 11 9 8 00000000 0 0000000f   1 4 12 10 5 00000000 0 000a555f
1 3 13 12 11 00000000 0 000a555f   1 6 14 9 0 00000004 1 00000001
1 0 15 0 0 00000111 1 00000111   1 0 15 0 0 00000222 1 00000222
1 0 16 15 0 00000000 1 00000222   1 2 17 13 0 0000ff00 1 00005500
1 1 18 15 14 00000000 0 00000221   1 7 19 2 14 00000000 0 00000001
1 4 20 15 0 00000fff 1 00000ddd   1 0 21 15 0 00000000 0 00000222
1 0 0 1 0 00000100 1 00000000   1 0 22 0 0 00000007 1 00000007
1 3 23 0 0 00000000 0 00000000   1 1 0 22 0 00000001 1 00000000
1 2 24 0 0 ffffffff 1 00000000   1 0 25 0 0 00000033 1 00000033
1 0 26 22 0 00000010 1 00000017   0 0 26 0 0 0000dead 1 00000000
0 0 27 0 0 0000beef 1 00000000   1 0 27 26 0 00000001 1 00000018
1 0 28 26 27 00000000 0 0000002f   0 0 28 0 0 00001234 1 00000000
0 0 0 0 0 00000000 0 00000000   0 0 0 0 0 00000000 0 00000000
1 5 29 27 0 00000002 1 00000060   1 6 30 28 0 00000001 1 00000017
1 7 31 2 0 00000000 0 00000001   1 1 1 0 28 00000000 0 ffffffd1
1 0 2 1 31 00000000 0 ffffffd2   1 5 3 30 8 00000000 0 0000002e
1 6 4 1 0 0000001c 1 0000000f   1 7 5 3 2 00000000 0 00000000

// ==== test/tb_dual_issue_core.sv ====
`timescale 1ns/1ns

module tb_dual_issue_core
    import core_pkg::*;
();

    localparam int    reset_cycles = 16;
    localparam int    lane_w       = 1 + reg_addr_w + xlen;
    localparam int    drain_limit  = pipe_latency + 4;
    localparam string case_file    = "test/core_cases.txt";

    logic                  clk;
    logic                  rstn;
    logic                  issue_valid_0, issue_valid_1;
    alu_op_e               op_0, op_1;
    logic [reg_addr_w-1:0] rd_0, rd_1;
    logic [reg_addr_w-1:0] rj_0, rj_1;
    logic [reg_addr_w-1:0] rk_0, rk_1;
    logic [xlen-1:0]       imm_0, imm_1;
    logic                  use_imm_0, use_imm_1;
    logic                  wb_en_0, wb_en_1;
    logic [reg_addr_w-1:0] wb_addr_0, wb_addr_1;
    logic [xlen-1:0]       wb_data_0, wb_data_1;

    // expected writebacks per lane as {en, addr, data} with the oldest first
    logic [lane_w-1:0] exp0_q[$];
    logic [lane_w-1:0] exp1_q[$];
    int                case_q[$];

    dual_issue_core i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_value(input string name, input logic [xlen-1:0] expected,
                                 input logic [xlen-1:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_idle();
        issue_valid_0 = 1'b0;
        issue_valid_1 = 1'b0;
        op_0          = op_add;
        op_1          = op_add;
        {rd_0, rj_0, rk_0, imm_0, use_imm_0} = '0;
        {rd_1, rj_1, rk_1, imm_1, use_imm_1} = '0;
    endtask

    // idle lanes and register zero never write back
    function automatic logic [lane_w-1:0] expect_lane(input logic valid,
                                                      input logic [reg_addr_w-1:0] rd,
                                                      input logic [xlen-1:0] data);
        return {valid && rd != '0, rd, data};
    endfunction

    task automatic push_expected(input int case_num, input logic [lane_w-1:0] want_0,
                                 input logic [lane_w-1:0] want_1);
        exp0_q.push_back(want_0);
        exp1_q.push_back(want_1);
        case_q.push_back(case_num);
    endtask

    task automatic check_lane(input int case_num, input int lane,
                              input logic [lane_w-1:0] want, input logic en,
                              input logic [reg_addr_w-1:0] addr, input logic [xlen-1:0] data);
        string name;
        name = $sformatf("case %0d lane %0d", case_num, lane);
        compare_value({name, " wb_en"}, xlen'(want[lane_w-1]), xlen'(en));
        // address and data only mean something with the enable set
        if (want[lane_w-1]) begin
            compare_value({name, " wb_addr"}, xlen'(want[lane_w-2 -: reg_addr_w]), xlen'(addr));
            compare_value({name, " wb_data"}, want[xlen-1:0], data);
        end
    endtask

    task automatic check_oldest();
        logic [lane_w-1:0] want_0;
        logic [lane_w-1:0] want_1;
        int                case_num;
        want_0   = exp0_q.pop_front();
        want_1   = exp1_q.pop_front();
        case_num = case_q.pop_front();
        check_lane(case_num, 0, want_0, wb_en_0, wb_addr_0, wb_data_0);
        check_lane(case_num, 1, want_1, wb_en_1, wb_addr_1, wb_data_1);
    endtask

    initial begin
        int                    fd;
        int                    n;
        int                    num_cases;
        int                    waited;
        string                 line;
        // fields of one case line for each lane
        logic                  v0, v1, ui0, ui1;
        logic [alu_op_w-1:0]   o0, o1;
        logic [reg_addr_w-1:0] d0, d1, j0, j1, k0, k1;
        logic [xlen-1:0]       i0, i1, x0, x1;

        num_cases = 0;
        waited    = 0;
        rstn      = 1'b0;
        drive_idle();

        for (int c = 0; c < reset_cycles; c++) begin
            next_cycle();
            compare_value("reset wb_en_0", '0, xlen'(wb_en_0));
            compare_value("reset wb_en_1", '0, xlen'(wb_en_1));
        end
        rstn = 1'b1;

        // nothing is in flight for the first pipe_latency cycles
        for (int c = 0; c < pipe_latency; c++) begin
            push_expected(0, '0, '0);
        end

        fd = $fopen(case_file, "r");
        if (fd == 0) begin
            $display("could not open the case file %s", case_file);
            stop_with_failure();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %d %d %d %h %d %h %d %d %d %d %d %h %d %h",
                        v0, o0, d0, j0, k0, i0, ui0, x0, v1, o1, d1, j1, k1, i1, ui1, x1);
            if (n != 16) begin
                $display("case file line has %0d fields instead of 16: %s", n, line);
                stop_with_failure();
            end
            num_cases++;
            next_cycle();
            check_oldest();
            issue_valid_0 = v0;
            op_0          = alu_op_e'(o0);
            {rd_0, rj_0, rk_0, imm_0, use_imm_0} = {d0, j0, k0, i0, ui0};
            issue_valid_1 = v1;
            op_1          = alu_op_e'(o1);
            {rd_1, rj_1, rk_1, imm_1, use_imm_1} = {d1, j1, k1, i1, ui1};
            push_expected(num_cases, expect_lane(v0, d0, x0), expect_lane(v1, d1, x1));
        end
        $fclose(fd);

        if (num_cases == 0) begin
            $display("the case file %s holds no issue pairs", case_file);
            stop_with_failure();
        end

        // flush the pairs still in the pipeline
        while (exp0_q.size() > 0 && waited < drain_limit) begin
            next_cycle();
            check_oldest();
            drive_idle();
            waited++;
        end

        if (exp0_q.size() != 0) begin
            $display("timed out waiting for the last %0d writebacks", exp0_q.size());
            stop_with_failure();
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
logic/core_pkg.sv
logic/register_file.sv
logic/operand_stage.sv
logic/forward_unit.sv
logic/exe_lane.sv
logic/dual_issue_core.sv
test/tb_dual_issue_core.sv
